// File: design/slc3_config.svh
`ifndef SLC3_CONFIG_SVH
`define SLC3_CONFIG_SVH

// Data and address word width of the CPU
`define SLC3_WORD_W 16

// Address width of the external SRAM chip
`define SLC3_SRAM_ADDR_W 20

// First instruction fetched after reset
`define SLC3_START_PC 16'h0000

// Switches on read, display register on write
`define SLC3_IO_ADDR 16'hFFFF

`endif

// File: design/slc3Pkg.sv
`include "slc3_config.svh"

package slc3Pkg;

	// Bus, register and memory word
	typedef logic [`SLC3_WORD_W-1:0] word_t;
	// Register number
	typedef logic [2:0] regIdx_t;
	// IR[15:12]
	typedef logic [3:0] opcode_t;

	localparam opcode_t opBr = 4'b0000;
	localparam opcode_t opAdd = 4'b0001;
	localparam opcode_t opLd = 4'b0010;
	localparam opcode_t opSt = 4'b0011;
	localparam opcode_t opJsr = 4'b0100;
	localparam opcode_t opAnd = 4'b0101;
	localparam opcode_t opLdr = 4'b0110;
	localparam opcode_t opStr = 4'b0111;
	localparam opcode_t opNot = 4'b1001;
	localparam opcode_t opJmp = 4'b1100;
	localparam opcode_t opPause = 4'b1101;
	localparam opcode_t opLea = 4'b1110;

	// PC mux selects
	localparam logic [1:0] pcInc = 2'd0;
	localparam logic [1:0] pcBus = 2'd1;
	localparam logic [1:0] pcAdder = 2'd2;

	// Address adder operands
	localparam logic a1Pc = 1'b0;
	localparam logic a1Base = 1'b1;
	localparam logic [1:0] a2Zero = 2'd0;
	localparam logic [1:0] a2Off6 = 2'd1;
	localparam logic [1:0] a2Off9 = 2'd2;
	localparam logic [1:0] a2Off11 = 2'd3;

	// ALU functions
	localparam logic [1:0] aluAdd = 2'd0;
	localparam logic [1:0] aluAnd = 2'd1;
	localparam logic [1:0] aluNot = 2'd2;
	localparam logic [1:0] aluPass = 2'd3;

	typedef struct packed {
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldBen;
		logic ldCc;
		logic ldReg;
		logic ldPc;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateMarMux;
		logic [1:0] pcMux;
		logic addr1Mux;
		logic [1:0] addr2Mux;
		logic [1:0] aluK;
		logic drR7;
		logic sr1FromBase;
		logic mioEn;
	} ctrl_t;

	// SRAM strobes, all active low
	typedef struct packed {
		logic ce;
		logic ub;
		logic lb;
		logic oe;
		logic we;
	} memCtrl_t;

	localparam memCtrl_t memIdle = '{ce: 1'b1, ub: 1'b1, lb: 1'b1, oe: 1'b1, we: 1'b1};
	localparam memCtrl_t memRead = '{ce: 1'b0, ub: 1'b0, lb: 1'b0, oe: 1'b0, we: 1'b1};
	localparam memCtrl_t memWrite = '{ce: 1'b0, ub: 1'b0, lb: 1'b0, oe: 1'b1, we: 1'b0};

endpackage

// File: design/isdu.sv
`timescale 1ns/1ns

module isdu import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input logic run,
	input logic cont,
	input opcode_t opcode,
	input logic ir5,
	input logic ir11,
	input logic ben,
	output ctrl_t ctrl,
	output memCtrl_t mem,
	output logic paused
);

	typedef enum logic [4:0] {
		sHalted,
		sFetch1,
		sFetchWait,
		sFetch2,
		sFetch3,
		sDecode,
		sAlu,
		sBr,
		sJmp,
		sJsr,
		sLea,
		sLdMar,
		sLdrMar,
		sRdWait,
		sRd,
		sLdReg,
		sStMar,
		sStrMar,
		sStMdr,
		sWrWait,
		sWr,
		sPauseHold,
		sPauseRel
	} state_t;

	state_t state;
	state_t stateNext;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= sHalted;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		unique case (state)
			sHalted: if (run) stateNext = sFetch1;
			sFetch1: stateNext = sFetchWait;
			sFetchWait: stateNext = sFetch2;
			sFetch2: stateNext = sFetch3;
			sFetch3: stateNext = sDecode;
			sDecode: begin
				case (opcode)
					opAdd, opAnd: stateNext = sAlu;
					// NOT is only legal with IR[5:0] all ones
					opNot: stateNext = ir5 ? sAlu : sFetch1;
					opBr: stateNext = sBr;
					opJmp: stateNext = sJmp;
					opJsr: stateNext = sJsr;
					opLea: stateNext = sLea;
					opLd: stateNext = sLdMar;
					opLdr: stateNext = sLdrMar;
					opSt: stateNext = sStMar;
					opStr: stateNext = sStrMar;
					opPause: stateNext = sPauseHold;
					// LDI, STI, TRAP, RTI fall through as no-ops
					default: stateNext = sFetch1;
				endcase
			end
			sLdMar, sLdrMar: stateNext = sRdWait;
			sRdWait: stateNext = sRd;
			sRd: stateNext = sLdReg;
			sStMar, sStrMar: stateNext = sStMdr;
			sStMdr: stateNext = sWrWait;
			sWrWait: stateNext = sWr;
			// Wait for press, then for release
			sPauseHold: if (cont) stateNext = sPauseRel;
			sPauseRel: if (!cont) stateNext = sFetch1;
			default: stateNext = sFetch1;
		endcase
	end

	assign paused = (state == sPauseHold) || (state == sPauseRel);

	always_comb begin
		ctrl = '0;
		mem = memIdle;
		unique case (state)
			// MAR <- PC, PC <- PC + 1
			sFetch1: begin
				ctrl.gatePc = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = pcInc;
			end
			sFetchWait, sRdWait: mem = memRead;
			// MDR captures on the second read cycle
			sFetch2, sRd: begin
				mem = memRead;
				ctrl.ldMdr = 1'b1;
				ctrl.mioEn = 1'b1;
			end
			sFetch3: begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldIr = 1'b1;
			end
			sDecode: ctrl.ldBen = 1'b1;
			sAlu: begin
				ctrl.gateAlu = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				ctrl.sr1FromBase = 1'b1;
				ctrl.aluK = (opcode == opAnd) ? aluAnd : (opcode == opNot) ? aluNot : aluAdd;
			end
			// Only taken branches load the PC
			sBr: begin
				ctrl.ldPc = ben;
				ctrl.pcMux = pcAdder;
				ctrl.addr1Mux = a1Pc;
				ctrl.addr2Mux = a2Off9;
			end
			// Base register reaches the PC over the bus
			sJmp: begin
				ctrl.gateMarMux = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = pcBus;
				ctrl.addr1Mux = a1Base;
				ctrl.sr1FromBase = 1'b1;
				ctrl.addr2Mux = a2Zero;
			end
			// R7 <- PC and PC <- target on the same edge, so JSRR R7 sees old R7
			sJsr: begin
				ctrl.gatePc = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.drR7 = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = pcAdder;
				ctrl.sr1FromBase = 1'b1;
				ctrl.addr1Mux = ir11 ? a1Pc : a1Base;
				ctrl.addr2Mux = ir11 ? a2Off11 : a2Zero;
			end
			sLea: begin
				ctrl.gateMarMux = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				ctrl.addr1Mux = a1Pc;
				ctrl.addr2Mux = a2Off9;
			end
			sLdMar, sStMar: begin
				ctrl.gateMarMux = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.addr1Mux = a1Pc;
				ctrl.addr2Mux = a2Off9;
			end
			sLdrMar, sStrMar: begin
				ctrl.gateMarMux = 1'b1;
				ctrl.ldMar = 1'b1;
				ctrl.addr1Mux = a1Base;
				ctrl.sr1FromBase = 1'b1;
				ctrl.addr2Mux = a2Off6;
			end
			sLdReg: begin
				ctrl.gateMdr = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			// SR in IR[11:9] passes through the ALU into MDR
			sStMdr: begin
				ctrl.gateAlu = 1'b1;
				ctrl.aluK = aluPass;
				ctrl.ldMdr = 1'b1;
			end
			sWrWait, sWr: mem = memWrite;
			default: ;
		endcase
	end

endmodule

// File: design/datapath.sv
`timescale 1ns/1ns
`include "slc3_config.svh"

module datapath import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input ctrl_t ctrl,
	input word_t sr1,
	input word_t sr2,
	input word_t memIn,
	output word_t bus,
	output word_t pc,
	output word_t ir,
	output word_t mar,
	output word_t mdr,
	output logic ben
);

	localparam int W = `SLC3_WORD_W;

	word_t aluB;
	word_t aluOut;
	word_t addr1;
	word_t addr2;
	word_t adderOut;
	word_t pcNext;
	logic [2:0] nzp;
	logic [2:0] nzpNext;

	// Sign-extended IR fields
	word_t imm5;
	word_t off6;
	word_t off9;
	word_t off11;

	assign imm5 = {{(W - 5){ir[4]}}, ir[4:0]};
	assign off6 = {{(W - 6){ir[5]}}, ir[5:0]};
	assign off9 = {{(W - 9){ir[8]}}, ir[8:0]};
	assign off11 = {{(W - 11){ir[10]}}, ir[10:0]};

	// One source on the bus at a time
	always_comb begin
		if (ctrl.gatePc) begin
			bus = pc;
		end else if (ctrl.gateMdr) begin
			bus = mdr;
		end else if (ctrl.gateAlu) begin
			bus = aluOut;
		end else if (ctrl.gateMarMux) begin
			bus = adderOut;
		end else begin
			bus = '0;
		end
	end

	// IR[5] picks the immediate form
	assign aluB = ir[5] ? imm5 : sr2;

	always_comb begin
		unique case (ctrl.aluK)
			aluAdd: aluOut = sr1 + aluB;
			aluAnd: aluOut = sr1 & aluB;
			aluNot: aluOut = ~sr1;
			default: aluOut = sr1;
		endcase
	end

	// Address adder, base plus offset
	assign addr1 = (ctrl.addr1Mux == a1Base) ? sr1 : pc;

	always_comb begin
		unique case (ctrl.addr2Mux)
			a2Off6: addr2 = off6;
			a2Off9: addr2 = off9;
			a2Off11: addr2 = off11;
			default: addr2 = '0;
		endcase
	end

	assign adderOut = addr1 + addr2;

	always_comb begin
		unique case (ctrl.pcMux)
			pcBus: pcNext = bus;
			pcAdder: pcNext = adderOut;
			default: pcNext = pc + 1'b1;
		endcase
	end

	// Condition codes from the value on the bus
	assign nzpNext = bus[W-1] ? 3'b100 : (bus == '0) ? 3'b010 : 3'b001;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `SLC3_START_PC;
			ir <= '0;
			mar <= '0;
			nzp <= 3'b000;
			ben <= 1'b0;
		end else begin
			if (ctrl.ldPc) pc <= pcNext;
			if (ctrl.ldIr) ir <= bus;
			if (ctrl.ldMar) mar <= bus;
			if (ctrl.ldCc) nzp <= nzpNext;
			// Branch mask against current flags
			if (ctrl.ldBen) ben <= |(ir[11:9] & nzp);
		end
	end

	// MDR loads from memory during a read, else from the bus
	always_ff @(posedge Clk) begin
		if (ctrl.ldMdr) mdr <= ctrl.mioEn ? memIn : bus;
	end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ns

module regFile import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input ctrl_t ctrl,
	input word_t ir,
	input word_t bus,
	output word_t sr1,
	output word_t sr2
);

	word_t regs [8];
	regIdx_t drIdx;
	regIdx_t sr1Idx;
	regIdx_t sr2Idx;

	// JSR links through R7
	assign drIdx = ctrl.drR7 ? regIdx_t'(3'd7) : ir[11:9];
	// Base register or store source
	assign sr1Idx = ctrl.sr1FromBase ? ir[8:6] : ir[11:9];
	assign sr2Idx = ir[2:0];

	assign sr1 = regs[sr1Idx];
	assign sr2 = regs[sr2Idx];

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.ldReg) begin
			regs[drIdx] <= bus;
		end
	end

endmodule

// File: design/mem2Io.sv
`timescale 1ns/1ns
`include "slc3_config.svh"

module mem2Io import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input word_t mar,
	input word_t mdr,
	input memCtrl_t mem,
	input word_t s,
	input word_t dataFromSram,
	output word_t memIn,
	output word_t dataToSram,
	output word_t hexWord
);

	logic ioSel;
	logic weQ;
	logic writeStart;

	assign ioSel = (mar == `SLC3_IO_ADDR);

	// Switches replace SRAM data at the I/O address
	assign memIn = ioSel ? s : dataFromSram;
	assign dataToSram = mdr;

	// First cycle of a write, we was high the cycle before
	assign writeStart = !mem.ce && !mem.we && weQ;

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			weQ <= 1'b1;
			hexWord <= '0;
		end else begin
			weQ <= mem.we;
			if (writeStart && ioSel) hexWord <= mdr;
		end
	end

endmodule

// File: design/slc3.sv
`timescale 1ns/1ns
`include "slc3_config.svh"

module slc3 import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input word_t s,
	input logic run,
	input logic cont,
	output logic [11:0] led,
	output word_t hexWord,
	output word_t pc,
	output word_t ir,
	output logic [`SLC3_SRAM_ADDR_W-1:0] addr,
	output memCtrl_t mem,
	output word_t dataToSram,
	input word_t dataFromSram,
	output logic paused
);

	// Buttons are active low on the board
	logic runPressed;
	logic contPressed;

	ctrl_t ctrl;
	logic ben;
	word_t bus;
	word_t sr1;
	word_t sr2;
	word_t mar;
	word_t mdr;
	word_t memIn;

	assign runPressed = ~run;
	assign contPressed = ~cont;

	// SRAM is 1M words but only the low 64K are reachable
	assign addr = {{(`SLC3_SRAM_ADDR_W - `SLC3_WORD_W){1'b0}}, mar};

	// Pause code from the instruction shows on the LEDs
	assign led = paused ? ir[11:0] : 12'h000;

	isdu uIsdu (
		.Clk(Clk),
		.arstN(arstN),
		.run(runPressed),
		.cont(contPressed),
		.opcode(ir[15:12]),
		.ir5(ir[5]),
		.ir11(ir[11]),
		.ben(ben),
		.ctrl(ctrl),
		.mem(mem),
		.paused(paused)
	);

	datapath uDatapath (
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.sr1(sr1),
		.sr2(sr2),
		.memIn(memIn),
		.bus(bus),
		.pc(pc),
		.ir(ir),
		.mar(mar),
		.mdr(mdr),
		.ben(ben)
	);

	regFile uRegFile (
		.Clk(Clk),
		.arstN(arstN),
		.ctrl(ctrl),
		.ir(ir),
		.bus(bus),
		.sr1(sr1),
		.sr2(sr2)
	);

	mem2Io uMem2Io (
		.Clk(Clk),
		.arstN(arstN),
		.mar(mar),
		.mdr(mdr),
		.mem(mem),
		.s(s),
		.dataFromSram(dataFromSram),
		.memIn(memIn),
		.dataToSram(dataToSram),
		.hexWord(hexWord)
	);

endmodule

// File: sim/slc3_props.sv
`timescale 1ns/1ns

module slc3_props import slc3Pkg::*; (
	input logic Clk,
	input logic arstN,
	input logic cont,
	input logic paused,
	input ctrl_t ctrl,
	input memCtrl_t mem,
	input logic [4:0] state
);

	// Read and write strobes never overlap
	oeWeExclusive: assert property (@(posedge Clk) disable iff (!arstN) !(!mem.oe && !mem.we))
		else $error("SRAM oe and we both low");

	// All strobes idle while reset is held
	idleInReset: assert property (@(posedge Clk) !arstN |-> (mem == memIdle))
		else $error("SRAM strobes active during reset");

	// No loads, gates or memory cycles while paused
	quietWhilePaused: assert property (@(posedge Clk) disable iff (!arstN)
		paused |-> (ctrl == '0 && mem == memIdle))
		else $error("control active while paused");

	// Pause state holds until Continue is pressed
	holdUntilCont: assert property (@(posedge Clk) disable iff (!arstN)
		(paused && !cont && !$past(cont)) |=> (paused && $stable(state)))
		else $error("pause state left without Continue");

endmodule

bind isdu slc3_props uProps (
	.Clk(Clk),
	.arstN(arstN),
	.cont(cont),
	.paused(paused),
	.ctrl(ctrl),
	.mem(mem),
	.state(state)
);

// File: sim/slc3Tb.sv
`timescale 1ns/1ns
`include "slc3_config.svh"

module slc3Tb import slc3Pkg::*; ();

	// Cycles allowed for a program to reach its PAUSE
	localparam int pauseTimeout = 5000;

	logic Clk;
	logic arstN;
	word_t s;
	logic run;
	logic cont;
	logic [11:0] led;
	word_t hexWord;
	word_t pc;
	word_t ir;
	logic [`SLC3_SRAM_ADDR_W-1:0] addr;
	memCtrl_t mem;
	word_t dataToSram;
	word_t dataFromSram;
	logic paused;

	// SRAM contents and the reference copy
	word_t sram [0:65535];
	word_t refMem [0:65535];
	word_t refReg [0:7];
	word_t refPc;
	word_t refHex;
	logic [2:0] refNzp;

	logic [31:0] lfsr;
	// Next program word to emit
	word_t loc;
	int errCount;
	int checkCount;
	int testCount;
	int failCount;
	bit timedOut;

	slc3 UUT (
		.Clk(Clk),
		.arstN(arstN),
		.s(s),
		.run(run),
		.cont(cont),
		.led(led),
		.hexWord(hexWord),
		.pc(pc),
		.ir(ir),
		.addr(addr),
		.mem(mem),
		.dataToSram(dataToSram),
		.dataFromSram(dataFromSram),
		.paused(paused)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Asynchronous SRAM answers reads within the cycle
	assign dataFromSram = sram[addr[15:0]];

	always @(posedge Clk) begin
		if (!mem.ce && !mem.we) sram[addr[15:0]] <= dataToSram;
	end

	// Fibonacci taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] v);
		return {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
	endfunction

	// One LFSR step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic checkEq(input string name, input word_t expected, input word_t actual);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Low n bits carry the field
	function automatic word_t sext(input word_t v, input int n);
		word_t r;
		r = v;
		for (int i = n; i < 16; i++) r[i] = v[n-1];
		return r;
	endfunction

	function automatic word_t readMem(input word_t a);
		return (a == `SLC3_IO_ADDR) ? s : refMem[a];
	endfunction

	task automatic writeMem(input word_t a, input word_t v);
		refMem[a] = v;
		if (a == `SLC3_IO_ADDR) refHex = v;
	endtask

	// Destination write plus NZP update
	task automatic writeReg(input logic [2:0] d, input word_t v);
		refReg[d] = v;
		refNzp = v[15] ? 3'b100 : (v == '0) ? 3'b010 : 3'b001;
	endtask

	// ISA-level execution up to and including the next PAUSE
	task automatic modelToPause(output word_t pauseIr);
		word_t inst;
		word_t opB;
		word_t target;
		logic [2:0] dr;
		logic [2:0] sr1;
		int steps;
		bit done;
		done = 0;
		steps = 0;
		pauseIr = '0;
		while (!done && steps < 4096) begin
			inst = refMem[refPc];
			refPc++;
			steps++;
			dr = inst[11:9];
			sr1 = inst[8:6];
			opB = inst[5] ? sext(inst, 5) : refReg[inst[2:0]];
			case (inst[15:12])
				opAdd: writeReg(dr, refReg[sr1] + opB);
				opAnd: writeReg(dr, refReg[sr1] & opB);
				opNot: writeReg(dr, ~refReg[sr1]);
				opBr: if ((inst[11:9] & refNzp) != 3'b000) refPc = refPc + sext(inst, 9);
				opJmp: refPc = refReg[sr1];
				// Base is read before R7 is linked
				opJsr: begin
					target = inst[11] ? refPc + sext(inst, 11) : refReg[sr1];
					refReg[7] = refPc;
					refPc = target;
				end
				opLd: writeReg(dr, readMem(refPc + sext(inst, 9)));
				opLdr: writeReg(dr, readMem(refReg[sr1] + sext(inst, 6)));
				opLea: writeReg(dr, refPc + sext(inst, 9));
				opSt: writeMem(refPc + sext(inst, 9), refReg[dr]);
				opStr: writeMem(refReg[sr1] + sext(inst, 6), refReg[dr]);
				opPause: begin
					pauseIr = inst;
					done = 1;
				end
				// LDI, STI, TRAP, RTI and reserved codes do nothing
				default: ;
			endcase
		end
		if (!done) begin
			errCount++;
			$display("Reference model ran %0d instructions without reaching PAUSE", steps);
		end
	endtask

	task automatic emit(input word_t w);
		sram[loc] = w;
		loc++;
	endtask

	// Offset from the word after the one about to be emitted
	function automatic logic [8:0] off9To(input word_t target);
		word_t d;
		d = target - loc - 16'd1;
		return d[8:0];
	endfunction

	// Code below x0080, data in x0080 to x00FF, pattern everywhere else
	task automatic fillMemory();
		for (int a = 0; a < 65536; a++) begin
			sram[a] = 16'(a * 16'h9E37) ^ 16'h5A5A;
		end
		for (int a = 16'h0080; a < 16'h0100; a++) begin
			sram[a] = 16'(takeBits(16));
		end
		s = 16'(takeBits(16));
		loc = '0;
	endtask

	task automatic loadAllRegs();
		for (int r = 0; r < 8; r++) begin
			emit({opLd, 3'(r), off9To(16'h0080 + 16'(takeBits(6)))});
		end
	endtask

	task automatic storeAllRegs(input word_t base);
		for (int r = 0; r < 8; r++) begin
			emit({opSt, 3'(r), off9To(base + 16'(r))});
		end
	endtask

	task automatic emitAluOp();
		logic [2:0] dr;
		logic [2:0] sr1;
		logic [2:0] sr2;
		logic [1:0] kind;
		dr = 3'(takeBits(3));
		sr1 = 3'(takeBits(3));
		sr2 = 3'(takeBits(3));
		kind = 2'(takeBits(2));
		case (kind)
			2'd0: emit({opAdd, dr, sr1, 3'b000, sr2});
			2'd1: emit({opAdd, dr, sr1, 1'b1, 5'(takeBits(5))});
			2'd2: begin
				if (takeBits(1) != 0) emit({opAnd, dr, sr1, 1'b1, 5'(takeBits(5))});
				else emit({opAnd, dr, sr1, 3'b000, sr2});
			end
			default: emit({opNot, dr, sr1, 6'b111111});
		endcase
	endtask

	task automatic buildAluProgram();
		int n;
		fillMemory();
		loadAllRegs();
		n = 12 + int'(takeBits(4));
		repeat (n) emitAluOp();
		storeAllRegs(16'h00C0);
		// R6 as STR base into the upper data area
		emit({opLea, 3'd6, off9To(16'h00E8)});
		for (int r = 0; r < 6; r++) begin
			emit({opStr, 3'(r), 3'd6, 6'(takeBits(6))});
		end
		emit({opPause, 12'(takeBits(12))});
	endtask

	task automatic buildLoadProgram();
		int n;
		logic [2:0] dr;
		logic [2:0] rb;
		fillMemory();
		n = 10 + int'(takeBits(3));
		for (int k = 0; k < n; k++) begin
			dr = 3'(takeBits(3));
			rb = 3'(takeBits(3));
			case (2'(takeBits(2)))
				2'd1: begin
					emit({opLea, rb, off9To(16'h00C0)});
					emit({opLdr, dr, rb, 6'(takeBits(6))});
				end
				2'd2: emit({opLea, dr, 9'(takeBits(9))});
				default: emit({opLd, dr, off9To(16'h0080 + 16'(takeBits(6)))});
			endcase
			emit({opSt, dr, off9To(16'h00E0 + 16'(k))});
		end
		emit({opPause, 12'(takeBits(12))});
	endtask

	// Forward jumps that each skip k filler words
	task automatic buildControlProgram();
		int k;
		logic [2:0] rb;
		fillMemory();
		loadAllRegs();
		for (int b = 0; b < 8; b++) begin
			k = int'(takeBits(2));
			rb = 3'(takeBits(3));
			case (2'(takeBits(2)))
				2'd2: emit({opJsr, 1'b1, 11'(k)});
				2'd3: begin
					emit({opLea, rb, 9'(k + 1)});
					emit({opJmp, 3'b000, rb, 6'b000000});
				end
				default: begin
					emit({opAdd, rb, 3'(takeBits(3)), 1'b1, 5'(takeBits(5))});
					emit({opBr, 3'(takeBits(3)), 9'(k)});
				end
			endcase
			repeat (k) emitAluOp();
			emit({opSt, 3'd7, off9To(16'h00E0 + 16'(b))});
		end
		storeAllRegs(16'h00C0);
		emit({opPause, 12'(takeBits(12))});
	endtask

	task automatic buildPauseProgram(input int nPauses);
		fillMemory();
		loadAllRegs();
		for (int p = 0; p < nPauses; p++) begin
			repeat (4 + int'(takeBits(2))) emitAluOp();
			storeAllRegs(16'h00C0 + 16'(8 * p));
			emit({opPause, 12'(takeBits(12))});
		end
	endtask

	// R1 holds xFFFF as base for the mapped I/O word
	task automatic buildIoProgram();
		fillMemory();
		loadAllRegs();
		emit({opAnd, 3'd1, 3'd1, 1'b1, 5'b00000});
		emit({opAdd, 3'd1, 3'd1, 1'b1, 5'b11111});
		emit({opStr, 3'd2, 3'd1, 6'd0});
		emit({opLdr, 3'd3, 3'd1, 6'd0});
		emit({opSt, 3'd3, off9To(16'h00C0)});
		emit({opStr, 3'd4, 3'd1, 6'd0});
		emit({opLdr, 3'd5, 3'd1, 6'd0});
		emit({opSt, 3'd5, off9To(16'h00C1)});
		emit({opPause, 12'(takeBits(12))});
	endtask

	task automatic applyReset();
		@(negedge Clk);
		arstN = 1'b0;
		repeat (10) @(negedge Clk);
		arstN = 1'b1;
	endtask

	task automatic waitPaused(input logic level, input int limit);
		int n;
		n = 0;
		while (paused !== level && n < limit) begin
			@(negedge Clk);
			n++;
		end
		if (paused !== level) begin
			timedOut = 1'b1;
			$display("Timeout: paused did not become %b within %0d cycles", level, limit);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errCount != errBefore || timedOut) begin
			failCount++;
			$display("%s: FAILED", name);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	task automatic testResetValues();
		int errBefore;
		errBefore = errCount;
		testCount++;
		applyReset();
		@(negedge Clk);
		checkEq("pc", `SLC3_START_PC, pc);
		checkEq("ir", 16'h0000, ir);
		checkEq("mem", {11'd0, memIdle}, {11'd0, mem});
		checkEq("paused", 16'd0, {15'd0, paused});
		checkEq("led", 16'h0000, {4'h0, led});
		reportTest("reset", errBefore);
	endtask

	task automatic runProgram(input string name, input int nPauses);
		int errBefore;
		word_t pauseIr;
		errBefore = errCount;
		testCount++;
		applyReset();
		for (int a = 0; a < 65536; a++) refMem[a] = sram[a];
		for (int r = 0; r < 8; r++) refReg[r] = '0;
		refPc = `SLC3_START_PC;
		refNzp = 3'b000;
		refHex = '0;
		// Active-low Run press for one cycle
		@(negedge Clk);
		run = 1'b0;
		@(negedge Clk);
		run = 1'b1;
		for (int p = 0; p < nPauses && !timedOut; p++) begin
			modelToPause(pauseIr);
			waitPaused(1'b1, pauseTimeout);
			if (!timedOut) begin
				checkEq("pc", refPc, pc);
				checkEq("ir", pauseIr, ir);
				checkEq("led", {4'h0, pauseIr[11:0]}, {4'h0, led});
				// Machine must sit still until Continue
				repeat (1 + int'(takeBits(4))) begin
					@(negedge Clk);
					checkEq("paused", 16'd1, {15'd0, paused});
					checkEq("pc", refPc, pc);
				end
				if (p < nPauses - 1) begin
					cont = 1'b0;
					repeat (2) @(negedge Clk);
					cont = 1'b1;
					waitPaused(1'b0, 2);
					checkEq("led", 16'h0000, {4'h0, led});
				end
			end
		end
		if (!timedOut) begin
			// First differing word only
			for (int a = 0; a < 65536; a++) begin
				if (sram[a] !== refMem[a]) begin
					checkEq($sformatf("sram[%04h]", a), refMem[a], sram[a]);
					break;
				end
			end
			checkEq("hexWord", refHex, hexWord);
		end
		reportTest(name, errBefore);
	endtask

	initial begin
		arstN = 1'b0;
		run = 1'b1;
		cont = 1'b1;
		s = '0;
		lfsr = 32'h97fa_6682;
		loc = '0;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		testResetValues();
		for (int i = 0; i < 3 && !timedOut; i++) begin
			buildAluProgram();
			runProgram($sformatf("alu %0d", i), 1);
		end
		for (int i = 0; i < 3 && !timedOut; i++) begin
			buildLoadProgram();
			runProgram($sformatf("loads %0d", i), 1);
		end
		for (int i = 0; i < 3 && !timedOut; i++) begin
			buildControlProgram();
			runProgram($sformatf("control %0d", i), 1);
		end
		for (int i = 0; i < 2 && !timedOut; i++) begin
			buildPauseProgram(3);
			runProgram($sformatf("pause %0d", i), 3);
		end
		for (int i = 0; i < 2 && !timedOut; i++) begin
			buildIoProgram();
			runProgram($sformatf("io %0d", i), 1);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failCount, checkCount, errCount);
		if (errCount == 0 && failCount == 0 && !timedOut) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/slc3Pkg.sv
design/isdu.sv
design/datapath.sv
design/regFile.sv
design/mem2Io.sv
design/slc3.sv
sim/slc3_props.sv
sim/slc3Tb.sv

// File: Bender.yml
package:
  name: slc3

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/slc3Pkg.sv
      - design/isdu.sv
      - design/datapath.sv
      - design/regFile.sv
      - design/mem2Io.sv
      - design/slc3.sv
      - target: simulation
        files:
          - sim/slc3_props.sv
          - sim/slc3Tb.sv
